// ==== hdl/tl45_pkg.sv ====
package tl45_pkg;

    typedef logic [31:0] word_t;      // Pc, instruction, immediate and data
    typedef logic [3:0]  reg_idx_t;   // Register index
    typedef logic [4:0]  opcode_t;    // Top five bits of the instruction

    // Opcode map, 04 is unassigned
    localparam opcode_t OP_NOP   = 5'h00;
    localparam opcode_t OP_ADD   = 5'h01;
    localparam opcode_t OP_SUB   = 5'h02;
    localparam opcode_t OP_MUL   = 5'h03;
    localparam opcode_t OP_SHRA  = 5'h05;
    localparam opcode_t OP_OR    = 5'h06;
    localparam opcode_t OP_XOR   = 5'h07;
    localparam opcode_t OP_AND   = 5'h08;
    localparam opcode_t OP_NOT   = 5'h09;
    localparam opcode_t OP_SHL   = 5'h0A;
    localparam opcode_t OP_SHR   = 5'h0B;
    localparam opcode_t OP_JMP   = 5'h0C;
    localparam opcode_t OP_CALL  = 5'h0D;
    localparam opcode_t OP_RET   = 5'h0E;
    localparam opcode_t OP_LBSE  = 5'h0F;
    localparam opcode_t OP_LHW   = 5'h10;
    localparam opcode_t OP_LHWSE = 5'h11;
    localparam opcode_t OP_LB    = 5'h12;
    localparam opcode_t OP_SB    = 5'h13;
    localparam opcode_t OP_LW    = 5'h14;
    localparam opcode_t OP_SW    = 5'h15;
    localparam opcode_t OP_SHW   = 5'h16;
    localparam opcode_t OP_DIV   = 5'h17;
    localparam opcode_t OP_UDIV  = 5'h18;

    localparam reg_idx_t REG_SP = 4'd15;   // Stack pointer

    localparam int NUM_REGS = 16;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t PC_STEP  = 32'd4;     // One word per instruction

    // Shift immediates must stay below this
    localparam int SHIFT_LIMIT = 32;

endpackage : tl45_pkg

// ==== hdl/tl45_pipe_if.sv ====
// Fetch buffer toward decode, stall and flush come back upstream
interface fetch_buf_if import tl45_pkg::*; ();

    word_t pc;
    word_t inst;
    logic  stall;
    logic  flush;

    modport fetch_mp (
        output pc,
        output inst,
        input  stall,
        input  flush
    );

    modport decode_mp (
        input  pc,
        input  inst,
        output stall,
        output flush
    );

endinterface : fetch_buf_if

// Decode buffer toward register read
interface decode_buf_if import tl45_pkg::*; ();

    word_t    pc;
    opcode_t  opcode;
    logic     ri;
    reg_idx_t dr;
    reg_idx_t sr1;
    reg_idx_t sr2;
    word_t    imm;
    logic     decode_err;
    logic     stall;
    logic     flush;

    modport decode_mp (
        output pc, opcode, ri, dr, sr1, sr2, imm, decode_err,
        input  stall, flush
    );

    modport regread_mp (
        input  pc, opcode, ri, dr, sr1, sr2, imm, decode_err,
        output stall, flush
    );

endinterface : decode_buf_if

// ==== hdl/tl45_fetch.sv ====
module tl45_fetch import tl45_pkg::*; (
    input  logic          i_clk,
    input  logic          i_arst_n,

    input  word_t         i_flush_pc,     // Redirect target

    // Instruction memory, answered in the same cycle
    output word_t         o_imem_addr,
    input  word_t         i_imem_data,

    fetch_buf_if.fetch_mp buf_out
);

    word_t pc;

    assign o_imem_addr = pc;

    // Program counter
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc <= RESET_PC;
        end else if (buf_out.flush) begin
            pc <= i_flush_pc;             // Redirect wins over stall
        end else if (!buf_out.stall) begin
            pc <= pc + PC_STEP;
        end
    end

    // Fetch buffer, an all-zero word is a bubble
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            buf_out.pc   <= '0;
            buf_out.inst <= '0;
        end else if (buf_out.flush) begin
            buf_out.pc   <= '0;
            buf_out.inst <= '0;
        end else if (!buf_out.stall) begin
            buf_out.pc   <= pc;
            buf_out.inst <= i_imem_data;
        end
    end

endmodule : tl45_fetch

// ==== hdl/tl45_decode.sv ====
module tl45_decode import tl45_pkg::*; (
    input  logic            i_clk,
    input  logic            i_arst_n,

    fetch_buf_if.decode_mp  buf_in,
    decode_buf_if.decode_mp buf_out
);

    // Raw fields, only meaningful for some opcodes
    opcode_t  opcode;
    logic     ri;
    logic     lh;
    logic     zs;
    logic [2:0] mode;
    reg_idx_t dr;
    reg_idx_t sr1;
    reg_idx_t sr2;
    logic [15:0] imm;
    logic [11:0] low_imm;         // Part of imm that does not overlap sr2

    word_t    resolved_imm;
    logic     sr2_force_sp;
    logic     inst_store;
    logic     shift_too_big;
    logic     alu_err;
    logic     shift_err;
    logic     decode_err;
    reg_idx_t dr_next;
    reg_idx_t sr2_next;

    assign {opcode, ri, lh, zs, dr, sr1, imm} = buf_in.inst;
    assign sr2     = buf_in.inst[15:12];
    assign low_imm = buf_in.inst[11:0];
    assign mode    = {ri, lh, zs};

    always_comb begin
        case ({lh, zs})
            2'b00:   resolved_imm = {16'b0, imm};            // Zero-extend
            2'b01:   resolved_imm = {{16{imm[15]}}, imm};    // Sign-extend
            default: resolved_imm = {imm, 16'b0};            // Load high
        endcase
    end

    // CALL and RET use the stack pointer as second source
    assign sr2_force_sp = (opcode == OP_CALL) || (opcode == OP_RET);

    // Stores name the data register in dr. Later stages expect every read
    // operand in sr1/sr2, so the data register moves to sr2 and dr is cleared.
    assign inst_store = (opcode == OP_SB) || (opcode == OP_SW) || (opcode == OP_SHW);

    assign dr_next = inst_store ? reg_idx_t'(0) : dr;

    always_comb begin
        if (sr2_force_sp) begin
            sr2_next = REG_SP;
        end else if (inst_store) begin
            sr2_next = dr;
        end else if (ri) begin
            sr2_next = '0;            // Immediate form has no second register
        end else begin
            sr2_next = sr2;
        end
    end

    assign shift_too_big = word_t'(imm) >= word_t'(SHIFT_LIMIT);

    // Register form must leave the mode and the low immediate bits clear
    assign alu_err   = !ri && ((mode != 3'b000) || (low_imm != '0));
    assign shift_err = ri ? shift_too_big : (mode != 3'b000);

    always_comb begin
        case (opcode)
            OP_NOP:    decode_err = buf_in.inst != '0;
            OP_ADD,
            OP_SUB,
            OP_MUL,
            OP_DIV,
            OP_UDIV,
            OP_OR,
            OP_XOR,
            OP_AND:    decode_err = alu_err;
            OP_NOT:    decode_err = (mode != 3'b000) || (low_imm != '0);
            OP_SHRA,
            OP_SHL,
            OP_SHR:    decode_err = shift_err;
            OP_JMP:    decode_err = mode != 3'b101;
            OP_CALL:   decode_err = mode != 3'b000;
            OP_RET:    decode_err = (mode != 3'b000) || (dr != REG_SP)
                                    || (sr1 != '0) || (imm != '0);
            OP_LBSE,
            OP_LHW,
            OP_LHWSE,
            OP_LB,
            OP_SB,
            OP_LW,
            OP_SW,
            OP_SHW:    decode_err = mode != 3'b001;    // Sign-extended offset
            default:   decode_err = 1'b1;              // Unassigned opcode
        endcase
    end

    assign buf_in.stall = buf_out.stall;
    assign buf_in.flush = buf_out.flush;

    // Fields pass through even when the encoding is illegal
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            buf_out.pc         <= '0;
            buf_out.opcode     <= '0;
            buf_out.ri         <= 1'b0;
            buf_out.dr         <= '0;
            buf_out.sr1        <= '0;
            buf_out.sr2        <= '0;
            buf_out.imm        <= '0;
            buf_out.decode_err <= 1'b0;
        end else if (buf_out.flush) begin
            buf_out.pc         <= '0;
            buf_out.opcode     <= '0;
            buf_out.ri         <= 1'b0;
            buf_out.dr         <= '0;
            buf_out.sr1        <= '0;
            buf_out.sr2        <= '0;
            buf_out.imm        <= '0;
            buf_out.decode_err <= 1'b0;
        end else if (!buf_out.stall) begin
            buf_out.pc         <= buf_in.pc;
            buf_out.opcode     <= opcode;
            buf_out.ri         <= ri;
            buf_out.dr         <= dr_next;
            buf_out.sr1        <= sr1;
            buf_out.sr2        <= sr2_next;
            buf_out.imm        <= resolved_imm;
            buf_out.decode_err <= decode_err;
        end
    end

endmodule : tl45_decode

// ==== hdl/tl45_regread.sv ====
module tl45_regread import tl45_pkg::*; (
    input  logic              i_clk,
    input  logic              i_arst_n,

    decode_buf_if.regread_mp  buf_in,

    input  logic              i_stall,
    input  logic              i_flush,

    // Writeback port
    input  logic              i_wb_en,
    input  reg_idx_t          i_wb_reg,
    input  word_t             i_wb_data,

    // Operand buffer toward execute
    output word_t             o_ex_pc,
    output opcode_t           o_ex_opcode,
    output logic              o_ex_ri,
    output reg_idx_t          o_ex_dr,
    output reg_idx_t          o_ex_sr1,
    output reg_idx_t          o_ex_sr2,
    output word_t             o_ex_imm,
    output word_t             o_ex_sr1_data,
    output word_t             o_ex_sr2_data,
    output logic              o_ex_decode_err
);

    word_t regs [NUM_REGS];
    word_t sr1_data;
    word_t sr2_data;

    // Register 0 reads zero, a matching writeback bypasses the file
    function automatic word_t read_operand(reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (i_wb_en && (i_wb_reg == idx)) begin
            value = i_wb_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    assign sr1_data = read_operand(buf_in.sr1);
    assign sr2_data = read_operand(buf_in.sr2);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_en && (i_wb_reg != '0)) begin
            regs[i_wb_reg] <= i_wb_data;     // Writes go on through stalls
        end
    end

    assign buf_in.stall = i_stall;
    assign buf_in.flush = i_flush;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            {o_ex_pc, o_ex_opcode, o_ex_ri, o_ex_dr, o_ex_sr1, o_ex_sr2} <= '0;
            {o_ex_imm, o_ex_sr1_data, o_ex_sr2_data, o_ex_decode_err} <= '0;
        end else if (i_flush) begin
            {o_ex_pc, o_ex_opcode, o_ex_ri, o_ex_dr, o_ex_sr1, o_ex_sr2} <= '0;
            {o_ex_imm, o_ex_sr1_data, o_ex_sr2_data, o_ex_decode_err} <= '0;
        end else if (!i_stall) begin
            o_ex_pc         <= buf_in.pc;
            o_ex_opcode     <= buf_in.opcode;
            o_ex_ri         <= buf_in.ri;
            o_ex_dr         <= buf_in.dr;
            o_ex_sr1        <= buf_in.sr1;
            o_ex_sr2        <= buf_in.sr2;
            o_ex_imm        <= buf_in.imm;
            o_ex_sr1_data   <= sr1_data;
            o_ex_sr2_data   <= sr2_data;
            o_ex_decode_err <= buf_in.decode_err;
        end
    end

endmodule : tl45_regread

// ==== hdl/tl45_frontend.sv ====
module tl45_frontend import tl45_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,

    // Pipeline control from the later stages
    input  logic     i_stall,
    input  logic     i_flush,
    input  word_t    i_flush_pc,
    output logic     o_stall_out,     // Control as seen at fetch
    output logic     o_flush_out,

    // Instruction memory
    output word_t    o_imem_addr,
    input  word_t    i_imem_data,

    // Writeback
    input  logic     i_wb_en,
    input  reg_idx_t i_wb_reg,
    input  word_t    i_wb_data,

    // Toward execute
    output word_t    o_ex_pc,
    output opcode_t  o_ex_opcode,
    output logic     o_ex_ri,
    output reg_idx_t o_ex_dr,
    output reg_idx_t o_ex_sr1,
    output reg_idx_t o_ex_sr2,
    output word_t    o_ex_imm,
    output word_t    o_ex_sr1_data,
    output word_t    o_ex_sr2_data,
    output logic     o_ex_decode_err
);

    fetch_buf_if  u_fetch_buf ();
    decode_buf_if u_decode_buf ();

    assign o_stall_out = u_fetch_buf.stall;
    assign o_flush_out = u_fetch_buf.flush;

    tl45_fetch u_fetch (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_flush_pc  (i_flush_pc),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .buf_out     (u_fetch_buf.fetch_mp)
    );

    tl45_decode u_decode (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .buf_in   (u_fetch_buf.decode_mp),
        .buf_out  (u_decode_buf.decode_mp)
    );

    tl45_regread u_regread (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .buf_in          (u_decode_buf.regread_mp),
        .i_stall         (i_stall),
        .i_flush         (i_flush),
        .i_wb_en         (i_wb_en),
        .i_wb_reg        (i_wb_reg),
        .i_wb_data       (i_wb_data),
        .o_ex_pc         (o_ex_pc),
        .o_ex_opcode     (o_ex_opcode),
        .o_ex_ri         (o_ex_ri),
        .o_ex_dr         (o_ex_dr),
        .o_ex_sr1        (o_ex_sr1),
        .o_ex_sr2        (o_ex_sr2),
        .o_ex_imm        (o_ex_imm),
        .o_ex_sr1_data   (o_ex_sr1_data),
        .o_ex_sr2_data   (o_ex_sr2_data),
        .o_ex_decode_err (o_ex_decode_err)
    );

endmodule : tl45_frontend

// ==== bench/tl45_frontend_assertions.sv ====
module tl45_frontend_assertions import tl45_pkg::*; (
    input logic    i_clk,
    input logic    i_arst_n,
    input logic    i_stall,
    input logic    i_flush,
    input word_t   o_imem_addr,
    input word_t   o_ex_pc,
    input opcode_t o_ex_opcode,
    input word_t   o_ex_imm,
    input word_t   o_ex_sr1_data,
    input logic    o_ex_decode_err
);

    // Stall without flush freezes the outputs and the pc
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_stall && !i_flush |=> $stable(o_ex_pc) && $stable(o_ex_opcode)
            && $stable(o_ex_imm) && $stable(o_ex_sr1_data) && $stable(o_imem_addr))
        else $error("outputs moved during a stall");

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_flush |=> o_ex_pc == '0 && o_ex_opcode == '0 && o_ex_imm == '0
            && !o_ex_decode_err)
        else $error("outputs not cleared by flush");

    assert property (@(posedge i_clk)
        !i_arst_n |-> o_ex_pc == '0 && o_ex_imm == '0 && o_ex_sr1_data == '0
            && o_imem_addr == RESET_PC)
        else $error("state not cleared in reset");

endmodule : tl45_frontend_assertions

bind tl45_frontend tl45_frontend_assertions u_assertions (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_stall         (i_stall),
    .i_flush         (i_flush),
    .o_imem_addr     (o_imem_addr),
    .o_ex_pc         (o_ex_pc),
    .o_ex_opcode     (o_ex_opcode),
    .o_ex_imm        (o_ex_imm),
    .o_ex_sr1_data   (o_ex_sr1_data),
    .o_ex_decode_err (o_ex_decode_err)
);

// ==== bench/tl45_frontend_tb.sv ====
module tl45_frontend_tb import tl45_pkg::*; ();

    localparam int CYCLE_LIMIT = 2000;   // Several times the total test length

    logic     i_clk;
    logic     i_arst_n;
    logic     i_stall;
    logic     i_flush;
    word_t    i_flush_pc;
    logic     o_stall_out;
    logic     o_flush_out;
    word_t    o_imem_addr;
    word_t    i_imem_data;
    logic     i_wb_en;
    reg_idx_t i_wb_reg;
    word_t    i_wb_data;
    word_t    o_ex_pc;
    opcode_t  o_ex_opcode;
    logic     o_ex_ri;
    reg_idx_t o_ex_dr;
    reg_idx_t o_ex_sr1;
    reg_idx_t o_ex_sr2;
    word_t    o_ex_imm;
    word_t    o_ex_sr1_data;
    word_t    o_ex_sr2_data;
    logic     o_ex_decode_err;

    word_t imem [256];
    word_t shadow [NUM_REGS];            // Expected register file
    int    base;                         // Word index of the program start
    int    seed = 25196;
    int    cycles = 0;

    tl45_frontend i_tl45_frontend (.*);

    always #50 i_clk = ~i_clk;

    assign i_imem_data = imem[o_imem_addr[9:2]];   // Same-cycle answer

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERROR time %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic compare_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("ERROR time %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic compare_opcode(input string name, input opcode_t exp, input opcode_t act);
        if (exp !== act) begin
            $display("ERROR time %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR time %0t: %s expected %b got %b", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // opcode, ri lh zs, dr, sr1, imm (upper nibble doubles as sr2)
    function automatic word_t encode(opcode_t op, logic [2:0] mode, reg_idx_t dr,
                                     reg_idx_t sr1, logic [15:0] imm);
        return {op, mode, dr, sr1, imm};
    endfunction

    // Expected decode of one instruction word
    task automatic ref_decode(input word_t inst, output opcode_t op, output logic ri,
                              output reg_idx_t dr, output reg_idx_t sr1,
                              output reg_idx_t sr2, output word_t imm, output logic err);
        logic        lh;
        logic        zs;
        logic [15:0] raw;
        op  = inst[31:27];
        ri  = inst[26];
        lh  = inst[25];
        zs  = inst[24];
        dr  = inst[23:20];
        sr1 = inst[19:16];
        raw = inst[15:0];
        sr2 = raw[15:12];
        if (lh)
            imm = {raw, 16'h0000};
        else if (zs)
            imm = {{16{raw[15]}}, raw};
        else
            imm = {16'h0000, raw};
        case (op)
            OP_NOP:  err = inst != '0;
            OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_UDIV, OP_OR, OP_XOR, OP_AND:
                     err = !ri && (lh || zs || raw[11:0] != '0);
            OP_NOT:  err = ri || lh || zs || raw[11:0] != '0;
            OP_SHRA, OP_SHL, OP_SHR:
                     err = ri ? (int'(raw) >= SHIFT_LIMIT) : (lh || zs);
            OP_JMP:  err = !(ri && !lh && zs);
            OP_CALL: err = ri || lh || zs;
            OP_RET:  err = ri || lh || zs || dr != REG_SP || sr1 != '0 || raw != '0;
            OP_LBSE, OP_LHW, OP_LHWSE, OP_LB, OP_SB, OP_LW, OP_SW, OP_SHW:
                     err = !(!ri && !lh && zs);
            default: err = 1'b1;
        endcase
        if (op == OP_CALL || op == OP_RET) begin
            sr2 = REG_SP;
        end else if (op == OP_SB || op == OP_SW || op == OP_SHW) begin
            sr2 = dr;
            dr  = '0;
        end else if (ri) begin
            sr2 = '0;
        end
    endtask

    function automatic word_t reg_value(reg_idx_t idx);
        return (idx == '0) ? '0 : shadow[idx];
    endfunction

    task automatic check_item(input int idx);
        opcode_t  op;
        logic     ri;
        logic     err;
        reg_idx_t dr;
        reg_idx_t s1;
        reg_idx_t s2;
        word_t    imm;
        ref_decode(imem[idx], op, ri, dr, s1, s2, imm, err);
        compare_word("o_ex_pc", word_t'(idx * 4), o_ex_pc);
        compare_opcode("o_ex_opcode", op, o_ex_opcode);
        compare_bit("o_ex_ri", ri, o_ex_ri);
        compare_reg("o_ex_dr", dr, o_ex_dr);
        compare_reg("o_ex_sr1", s1, o_ex_sr1);
        compare_reg("o_ex_sr2", s2, o_ex_sr2);
        compare_word("o_ex_imm", imm, o_ex_imm);
        compare_word("o_ex_sr1_data", reg_value(s1), o_ex_sr1_data);
        compare_word("o_ex_sr2_data", reg_value(s2), o_ex_sr2_data);
        compare_bit("o_ex_decode_err", err, o_ex_decode_err);
    endtask

    task automatic check_bubble();
        compare_word("o_ex_pc", '0, o_ex_pc);
        compare_opcode("o_ex_opcode", '0, o_ex_opcode);
        compare_bit("o_ex_ri", 1'b0, o_ex_ri);
        compare_reg("o_ex_dr", '0, o_ex_dr);
        compare_reg("o_ex_sr1", '0, o_ex_sr1);
        compare_reg("o_ex_sr2", '0, o_ex_sr2);
        compare_word("o_ex_imm", '0, o_ex_imm);
        compare_word("o_ex_sr1_data", '0, o_ex_sr1_data);
        compare_word("o_ex_sr2_data", '0, o_ex_sr2_data);
        compare_bit("o_ex_decode_err", 1'b0, o_ex_decode_err);
    endtask

    // Legal ADD immediates everywhere outside the program
    task automatic fill_memory();
        for (int i = 0; i < 256; i++)
            imem[i] = encode(OP_ADD, 3'b100, 4'd1, 4'd2, {8'h00, 8'(i)});
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_arst_n = 1'b0;
        repeat (8) @(negedge i_clk);
        for (int r = 0; r < NUM_REGS; r++)
            shadow[r] = '0;
        compare_word("o_imem_addr", RESET_PC, o_imem_addr);
        check_bubble();
        i_arst_n = 1'b1;
    endtask

    // Fill registers 1..15 while the pipeline is stalled
    task automatic load_writebacks();
        i_stall = 1'b1;
        for (int r = 1; r < NUM_REGS; r++) begin
            i_wb_en   = 1'b1;
            i_wb_reg  = reg_idx_t'(r);
            i_wb_data = $random(seed);
            @(negedge i_clk);
            shadow[r] = i_wb_data;
        end
        i_wb_en = 1'b0;
        i_stall = 1'b0;
    endtask

    task automatic make_random_program(input int n);
        word_t rnd;
        for (int k = 0; k < n; k++) begin
            rnd = $random(seed);
            imem[base + k] = encode(OP_ADD, 3'b000, rnd[3:0], rnd[7:4], {rnd[11:8], 12'h000});
        end
    endtask

    // Item shown stays on the outputs, a negative index means a bubble
    task automatic hold_stall(input int shown, input word_t addr);
        i_stall = 1'b1;
        repeat (3) begin
            @(posedge i_clk);
            @(negedge i_clk);
            compare_bit("o_stall_out", 1'b1, o_stall_out);
            compare_word("o_imem_addr", addr, o_imem_addr);
            if (shown >= 0)
                check_item(shown);
            else
                check_bubble();
        end
        i_stall = 1'b0;
    endtask

    // Item k shows on the o_ex outputs after edge k+3
    task automatic run_items(input int n, input int fwd_k, input int stall_e);
        opcode_t  op;
        logic     ri;
        logic     err;
        reg_idx_t dr;
        reg_idx_t s1;
        reg_idx_t s2;
        word_t    imm;
        for (int e = 1; e <= n + 2; e++) begin
            if (e == stall_e)
                hold_stall((e >= 4) ? base + e - 4 : -1, word_t'((base + e - 1) * 4));
            if (fwd_k >= 0 && e == fwd_k + 3) begin
                ref_decode(imem[base + fwd_k], op, ri, dr, s1, s2, imm, err);
                i_wb_en    = 1'b1;
                i_wb_reg   = s1;
                i_wb_data  = $random(seed);
                shadow[s1] = i_wb_data;          // Must reach the operand now
            end
            @(posedge i_clk);
            @(negedge i_clk);
            i_wb_en = 1'b0;
            if (e >= 3)
                check_item(base + e - 3);
            else
                check_bubble();
        end
    endtask

    task automatic test_fields();
        fill_memory();
        base = 0;
        imem[0] = encode(OP_ADD, 3'b000, 4'd3, 4'd1, 16'h2000);
        imem[1] = encode(OP_ADD, 3'b100, 4'd4, 4'd2, 16'h8123);
        imem[2] = encode(OP_ADD, 3'b101, 4'd5, 4'd3, 16'h8001);
        imem[3] = encode(OP_ADD, 3'b110, 4'd6, 4'd4, 16'h1234);
        imem[4] = encode(OP_SW, 3'b001, 4'd7, 4'd5, 16'hFFF0);
        imem[5] = encode(OP_SB, 3'b001, 4'd8, 4'd6, 16'h0004);
        imem[6] = encode(OP_SHW, 3'b001, 4'd9, 4'd7, 16'h8002);
        imem[7] = encode(OP_CALL, 3'b000, 4'd2, 4'd3, 16'h0040);
        imem[8] = encode(OP_RET, 3'b000, REG_SP, 4'd0, 16'h0000);
        apply_reset();
        run_items(9, -1, 0);
    endtask

    task automatic test_illegal();
        fill_memory();
        base = 0;
        imem[0] = 32'h0000_0001;                              // Nonzero NOP
        imem[1] = encode(OP_SHL, 3'b100, 4'd1, 4'd2, 16'd40);
        imem[2] = encode(OP_JMP, 3'b000, 4'd0, 4'd3, 16'h0010);
        imem[3] = encode(OP_RET, 3'b000, 4'd3, 4'd0, 16'h0000);
        imem[4] = encode(5'h04, 3'b000, 4'd1, 4'd1, 16'h0000);
        imem[5] = encode(5'h1F, 3'b010, 4'd2, 4'd3, 16'h5555);
        apply_reset();
        run_items(6, -1, 0);
    endtask

    task automatic test_regread();
        fill_memory();
        base = 0;
        make_random_program(6);
        imem[0] = encode(OP_ADD, 3'b000, 4'd1, 4'd0, 16'h0000);   // Both read r0
        imem[2] = encode(OP_ADD, 3'b000, 4'd2, 4'd5, 16'h5000);
        apply_reset();
        load_writebacks();
        run_items(6, 2, 0);
    endtask

    task automatic test_stall();
        fill_memory();
        base = 0;
        make_random_program(8);
        apply_reset();
        load_writebacks();
        run_items(8, -1, 4);
    endtask

    task automatic test_flush();
        fill_memory();
        base = 0;
        make_random_program(4);
        apply_reset();
        load_writebacks();
        run_items(4, -1, 0);
        i_flush    = 1'b1;
        i_flush_pc = 32'h0000_0100;
        @(posedge i_clk);
        @(negedge i_clk);
        compare_bit("o_flush_out", 1'b1, o_flush_out);
        i_flush = 1'b0;
        check_bubble();
        compare_word("o_imem_addr", 32'h0000_0100, o_imem_addr);
        base = 64;
        make_random_program(4);
        run_items(4, -1, 0);
    endtask

    initial begin
        i_clk      = 1'b0;
        i_arst_n   = 1'b0;
        i_stall    = 1'b0;
        i_flush    = 1'b0;
        i_flush_pc = '0;
        i_wb_en    = 1'b0;
        i_wb_reg   = '0;
        i_wb_data  = '0;
        base       = 0;
        fill_memory();
        test_fields();
        test_illegal();
        test_regread();
        test_stall();
        test_flush();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tl45_frontend_tb

// ==== src.f ====
hdl/tl45_pkg.sv
hdl/tl45_pipe_if.sv
hdl/tl45_fetch.sv
hdl/tl45_decode.sv
hdl/tl45_regread.sv
hdl/tl45_frontend.sv
bench/tl45_frontend_assertions.sv
bench/tl45_frontend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tl45_frontend_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

PASS_TEXT := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
